//--- files.f
hdl/fir_pkg.sv
hdl/fir_mac.sv
hdl/fir_addr_gen.sv
hdl/fir_ap_fsm.sv
hdl/fir_lite_regs.sv
hdl/fir_top.sv
dv/fir_props.sv
dv/fir_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f files.f --top-module fir_tb
	./obj_dir/Vfir_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

//--- dv/fir_tb.sv
// runs under Verilator with --timing and --assert; RAM models hold 1024 words with a one-cycle read
`default_nettype none

module fir_tb;
  localparam int n_samples = 40;
  localparam int n_taps = 11;
  localparam int taps_max = 32;
  // clear plus per-sample MAC latency and sink stalls
  localparam int run_cycles = taps_max + 2 + n_samples * (n_taps + 10);
  localparam int watchdog_cycles = 2 * run_cycles + 1500;

  logic        axis_clk;
  logic        axis_rst_n;
  logic        awvalid, wvalid, arvalid, rready;
  logic [11:0] awaddr, araddr;
  logic [31:0] wdata;
  wire         awready, wready, arready, rvalid;
  wire  [31:0] rdata;
  logic        ss_tvalid, ss_tlast, sm_tready;
  logic [31:0] ss_tdata;
  wire         ss_tready, sm_tvalid, sm_tlast;
  wire  [31:0] sm_tdata;
  wire  [3:0]  tap_we, data_we;
  wire         tap_en, data_en;
  wire  [11:0] tap_a, data_a;
  wire  [31:0] tap_di, data_di;
  logic [31:0] tap_do = '0;
  logic [31:0] data_do = '0;

  logic [31:0] tap_mem [1024];
  logic [31:0] data_mem [1024];
  logic [31:0] h [n_taps];
  logic [31:0] xs [n_samples];
  logic [31:0] got_data [$];
  bit          got_last [$];
  logic [31:0] tap_probe;
  logic [31:0] rng = 32'h5058d653;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  fir_top #(.num_taps_max(taps_max)) uut (.*);

  initial begin
    axis_clk = 1'b0;
    forever #4 axis_clk = ~axis_clk;
  end

  // junk in every word so a missed clear shows up in the sums
  initial begin
    for (int a = 0; a < 1024; a++) begin
      tap_mem[a]  = 32'h7a900000 ^ 32'(a);
      data_mem[a] = 32'hd5a00000 ^ (32'(a) * 32'h00010001);
    end
  end

  // byte-enable write and registered read of the old word
  always @(posedge axis_clk) begin
    if (tap_en) begin
      for (int b = 0; b < 4; b++) begin
        if (tap_we[b]) tap_mem[tap_a[11:2]][8*b +: 8] <= tap_di[8*b +: 8];
      end
      tap_do <= tap_mem[tap_a[11:2]];
    end
    if (data_en) begin
      for (int b = 0; b < 4; b++) begin
        if (data_we[b]) data_mem[data_a[11:2]][8*b +: 8] <= data_di[8*b +: 8];
      end
      data_do <= data_mem[data_a[11:2]];
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  // y[k] from the last n_taps samples, zero before the first one
  function automatic logic [31:0] model_output(input int k);
    logic [31:0] acc;
    acc = '0;
    for (int i = 0; i < n_taps; i++) begin
      if (k - i >= 0) acc = acc + h[i] * xs[k - i];
    end
    return acc;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    bit aw_done;
    bit w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!(aw_done && w_done)) begin
      // handshake completes at the coming rising edge
      if (awvalid && awready) aw_done = 1'b1;
      if (wvalid && wready) w_done = 1'b1;
      @(negedge axis_clk);
      if (aw_done) awvalid = 1'b0;
      if (w_done) wvalid = 1'b0;
    end
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge axis_clk);
    @(negedge axis_clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge axis_clk);
    // response waits one stall cycle for rready
    @(negedge axis_clk);
    rready = 1'b1;
    data   = rdata;
    @(negedge axis_clk);
    rready = 1'b0;
  endtask

  task automatic feed_samples();
    for (int k = 0; k < n_samples; k++) begin
      ss_tvalid = 1'b1;
      ss_tdata  = xs[k];
      ss_tlast  = (k == n_samples - 1);
      while (!ss_tready) @(negedge axis_clk);
      @(negedge axis_clk);
    end
    ss_tvalid = 1'b0;
    ss_tlast  = 1'b0;
  endtask

  task automatic collect_outputs();
    logic [31:0] r;
    got_data.delete();
    got_last.delete();
    while (got_data.size() < n_samples) begin
      r = next_rand();
      // ready about three cycles in four
      sm_tready = (r[17:16] != 2'd0);
      if (sm_tvalid && sm_tready) begin
        got_data.push_back(sm_tdata);
        got_last.push_back(sm_tlast);
      end
      @(negedge axis_clk);
    end
    sm_tready = 1'b0;
  endtask

  task automatic run_filter(input bit probe_taps);
    write_reg(fir_pkg::reg_ap_ctrl, 32'd1);
    fork
      feed_samples();
      collect_outputs();
      if (probe_taps) begin
        repeat (60) @(negedge axis_clk);
        read_reg(fir_pkg::tap_base + 12'h008, tap_probe);
      end
    join
  endtask

  initial begin
    logic [31:0] v;
    int mark;
    axis_rst_n = 1'b0;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b0;
    ss_tvalid  = 1'b0;
    ss_tdata   = '0;
    ss_tlast   = 1'b0;
    sm_tready  = 1'b0;
    repeat (2) @(posedge axis_clk);
    @(negedge axis_clk);
    axis_rst_n = 1'b1;
    @(negedge axis_clk);

    mark = errors;
    read_reg(fir_pkg::reg_ap_ctrl, v);
    expect_eq("idle_after_reset", 32'd4, v);
    finish_test("idle_after_reset", mark);

    mark = errors;
    write_reg(fir_pkg::reg_data_length, 32'(n_samples));
    write_reg(fir_pkg::reg_coef_length, 32'(n_taps));
    for (int i = 0; i < n_taps; i++) begin
      h[i] = next_rand();
      write_reg(fir_pkg::tap_base + 12'(4 * i), h[i]);
    end
    read_reg(fir_pkg::reg_data_length, v);
    expect_eq("register_readback", 32'(n_samples), v);
    read_reg(fir_pkg::reg_coef_length, v);
    expect_eq("register_readback", 32'(n_taps), v);
    for (int i = 0; i < n_taps; i++) begin
      read_reg(fir_pkg::tap_base + 12'(4 * i), v);
      expect_eq("register_readback", h[i], v);
    end
    finish_test("register_readback", mark);

    mark = errors;
    for (int k = 0; k < n_samples; k++) xs[k] = next_rand();
    run_filter(1'b0);
    for (int k = 0; k < n_samples; k++) begin
      expect_eq("filter_outputs", model_output(k), got_data[k]);
    end
    finish_test("filter_outputs", mark);

    mark = errors;
    for (int k = 0; k < n_samples; k++) begin
      expect_eq("end_of_run", 32'(k == n_samples - 1), 32'(got_last[k]));
    end
    read_reg(fir_pkg::reg_ap_ctrl, v);
    expect_eq("end_of_run", 32'd1, 32'(v[fir_pkg::ap_done_bit]));
    read_reg(fir_pkg::reg_ap_ctrl, v);
    expect_eq("end_of_run", 32'd4, v);
    finish_test("end_of_run", mark);

    // fresh samples so leftover window data would change the sums
    mark = errors;
    for (int k = 0; k < n_samples; k++) xs[k] = next_rand();
    run_filter(1'b1);
    for (int k = 0; k < n_samples; k++) begin
      expect_eq("fresh_second_run", model_output(k), got_data[k]);
    end
    read_reg(fir_pkg::reg_ap_ctrl, v);
    read_reg(fir_pkg::reg_ap_ctrl, v);
    expect_eq("fresh_second_run", 32'd4, v);
    finish_test("fresh_second_run", mark);

    mark = errors;
    expect_eq("tap_read_in_run", 32'hffffffff, tap_probe);
    finish_test("tap_read_in_run", mark);

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge axis_clk);
    $display("watchdog: simulation still running after %0d cycles", watchdog_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/fir_props.sv
// stream and AXI-Lite protocol checks on fir_top, inactive while axis_rst_n is low
`default_nettype none

module fir_props (
  input wire                       axis_clk,
  input wire                       axis_rst_n,
  input wire                       ss_tready,
  input wire                       sm_tvalid,
  input wire                       sm_tready,
  input wire [fir_pkg::data_w-1:0] sm_tdata,
  input wire                       rvalid,
  input wire                       rready,
  input wire [fir_pkg::data_w-1:0] rdata
);

  // output word holds while the sink stalls
  sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
    else $error("sm_tdata or sm_tvalid changed during a stall");

  // one sample in flight at a time
  stream_excl: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    !(ss_tready && sm_tvalid))
    else $error("ss_tready and sm_tvalid high together");

  rd_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("read response dropped or changed before rready");

endmodule

bind fir_top fir_props u_props (
  .axis_clk(axis_clk),
  .axis_rst_n(axis_rst_n),
  .ss_tready(ss_tready),
  .sm_tvalid(sm_tvalid),
  .sm_tready(sm_tready),
  .sm_tdata(sm_tdata),
  .rvalid(rvalid),
  .rready(rready),
  .rdata(rdata)
);

`default_nettype wire

//--- hdl/fir_top.sv
// FIR engine top; both RAMs are external with a one-cycle registered read, ss_tlast is ignored
`default_nettype none

module fir_top #(
  parameter int num_taps_max = 32
) (
  output wire                        awready,
  output wire                        wready,
  input  wire                        awvalid,
  input  wire [fir_pkg::addr_w-1:0]  awaddr,
  input  wire                        wvalid,
  input  wire [fir_pkg::data_w-1:0]  wdata,
  output wire                        arready,
  input  wire                        rready,
  input  wire                        arvalid,
  input  wire [fir_pkg::addr_w-1:0]  araddr,
  output wire                        rvalid,
  output wire [fir_pkg::data_w-1:0]  rdata,
  input  wire                        ss_tvalid,
  input  wire [fir_pkg::data_w-1:0]  ss_tdata,
  // output count comes from data_length
  input  wire                        ss_tlast,
  output wire                        ss_tready,
  input  wire                        sm_tready,
  output wire                        sm_tvalid,
  output wire [fir_pkg::data_w-1:0]  sm_tdata,
  output wire                        sm_tlast,
  output wire [3:0]                  tap_we,
  output wire                        tap_en,
  output wire [fir_pkg::data_w-1:0]  tap_di,
  output wire [fir_pkg::addr_w-1:0]  tap_a,
  input  wire [fir_pkg::data_w-1:0]  tap_do,
  output wire [3:0]                  data_we,
  output wire                        data_en,
  output wire [fir_pkg::data_w-1:0]  data_di,
  output wire [fir_pkg::addr_w-1:0]  data_a,
  input  wire [fir_pkg::data_w-1:0]  data_do,
  input  wire                        axis_clk,
  input  wire                        axis_rst_n
);
  fir_pkg::fir_cfg_t           cfg;
  fir_pkg::run_state_t         state;
  fir_pkg::bram_port_t         tap_port;
  fir_pkg::bram_port_t         data_port;
  fir_pkg::mac_ctl_t           mac_ctl;
  logic                        start;
  logic                        done_ack;
  logic                        clear_last;
  logic                        tap_last;
  logic                        out_last;
  logic [fir_pkg::addr_w-1:0]  tap_run_addr;

  fir_lite_regs #(.num_taps_max(num_taps_max)) u_regs (
    .axis_clk, .axis_rst_n,
    .awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
    .arvalid, .araddr, .arready, .rvalid, .rready, .rdata,
    .state, .tap_run_addr, .tap_do, .cfg, .start, .done_ack, .tap_port
  );

  fir_ap_fsm u_fsm (
    .axis_clk, .axis_rst_n, .start, .done_ack,
    .clear_last, .tap_last, .out_last, .ss_tvalid, .sm_tready,
    .state, .ss_tready, .sm_tvalid, .sm_tlast, .mac_ctl
  );

  fir_addr_gen #(.num_taps_max(num_taps_max)) u_addr (
    .axis_clk, .axis_rst_n, .state, .cfg, .ss_tdata, .sm_tready,
    .data_port, .tap_run_addr, .clear_last, .tap_last, .out_last
  );

  fir_mac u_mac (
    .axis_clk, .axis_rst_n, .mac_ctl, .data_do, .tap_do, .sm_tdata
  );

  // BRAM pins
  assign tap_we  = tap_port.we;
  assign tap_en  = tap_port.en;
  assign tap_a   = tap_port.addr;
  assign tap_di  = tap_port.di;
  assign data_we = data_port.we;
  assign data_en = data_port.en;
  assign data_a  = data_port.addr;
  assign data_di = data_port.di;

endmodule

`default_nettype wire

//--- hdl/fir_lite_regs.sv
// one read in flight; coef_length is clamped to 1..num_taps_max; tap writes are dropped during a run
`default_nettype none

module fir_lite_regs #(
  parameter int num_taps_max = 32
) (
  input  wire                          axis_clk,
  input  wire                          axis_rst_n,
  input  wire                          awvalid,
  input  wire [fir_pkg::addr_w-1:0]    awaddr,
  output logic                         awready,
  input  wire                          wvalid,
  input  wire [fir_pkg::data_w-1:0]    wdata,
  output logic                         wready,
  input  wire                          arvalid,
  input  wire [fir_pkg::addr_w-1:0]    araddr,
  output logic                         arready,
  output logic                         rvalid,
  input  wire                          rready,
  output logic [fir_pkg::data_w-1:0]   rdata,
  input  wire fir_pkg::run_state_t     state,
  input  wire [fir_pkg::addr_w-1:0]    tap_run_addr,
  input  wire [fir_pkg::data_w-1:0]    tap_do,
  output fir_pkg::fir_cfg_t            cfg,
  output logic                         start,
  output logic                         done_ack,
  output fir_pkg::bram_port_t          tap_port
);
  localparam int unsigned aw = fir_pkg::addr_w;
  localparam int unsigned dw = fir_pkg::data_w;
  localparam logic [dw-1:0] coef_max = dw'(num_taps_max);
  localparam logic [dw-1:0] coef_min = dw'(1);

  logic          aw_held;
  logic          w_held;
  logic [aw-1:0] awaddr_q;
  logic [dw-1:0] wdata_q;
  logic          wr_fire;
  logic          ar_fire;
  logic          rd_pend;
  logic          rd_s1;
  logic [aw-1:0] araddr_q;
  logic [dw-1:0] rd_word;
  logic [dw-1:0] ap_ctrl;
  logic [dw-1:0] coef_clamped;
  logic          running;

  assign running = (state != fir_pkg::idle) && (state != fir_pkg::done);

  // write channel holds, the register write needs both halves
  assign awready = !aw_held;
  assign wready  = !w_held;
  assign wr_fire = aw_held && w_held;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
    end else if (wr_fire) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        aw_held <= 1'b1;
      end
      if (wvalid && wready) begin
        w_held <= 1'b1;
      end
    end
  end

  always_comb begin
    if (wdata_q > coef_max) begin
      coef_clamped = coef_max;
    end else if (wdata_q < coef_min) begin
      coef_clamped = coef_min;
    end else begin
      coef_clamped = wdata_q;
    end
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      cfg <= '0;
    end else if (wr_fire) begin
      if (awaddr_q == fir_pkg::reg_data_length) begin
        cfg.data_length <= wdata_q;
      end
      if (awaddr_q == fir_pkg::reg_coef_length) begin
        cfg.coef_length <= coef_clamped;
      end
    end
  end

  // ap_ctrl is never stored, it mirrors the run state
  always_comb begin
    ap_ctrl = '0;
    ap_ctrl[fir_pkg::ap_start_bit] = running;
    ap_ctrl[fir_pkg::ap_done_bit]  = (state == fir_pkg::done);
    ap_ctrl[fir_pkg::ap_idle_bit]  = (state == fir_pkg::idle);
  end

  assign start = wr_fire && (awaddr_q == fir_pkg::reg_ap_ctrl)
                 && wdata_q[fir_pkg::ap_start_bit] && (state == fir_pkg::idle);

  // read path: address, tap RAM read, then registered rdata
  assign arready = !rd_pend && !wr_fire;
  assign ar_fire = arvalid && arready;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rd_pend <= 1'b0;
      rd_s1   <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      rd_s1 <= ar_fire;
      if (ar_fire) begin
        rd_pend <= 1'b1;
      end else if (rvalid && rready) begin
        rd_pend <= 1'b0;
      end
      if (rd_s1) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_comb begin
    case (araddr_q)
      fir_pkg::reg_ap_ctrl:     rd_word = ap_ctrl;
      fir_pkg::reg_data_length: rd_word = cfg.data_length;
      fir_pkg::reg_coef_length: rd_word = cfg.coef_length;
      default: begin
        if (araddr_q >= fir_pkg::tap_base) begin
          rd_word = running ? '1 : tap_do;
        end else begin
          rd_word = '0;
        end
      end
    endcase
  end

  always_ff @(posedge axis_clk) begin
    if (awvalid && awready) begin
      awaddr_q <= awaddr;
    end
    if (wvalid && wready) begin
      wdata_q <= wdata;
    end
    if (ar_fire) begin
      araddr_q <= araddr;
    end
    if (rd_s1) begin
      rdata <= rd_word;
    end
  end

  assign done_ack = rvalid && rready && (araddr_q == fir_pkg::reg_ap_ctrl)
                    && (state == fir_pkg::done);

  // tap RAM belongs to the engine while running
  always_comb begin
    tap_port = '0;
    if (running) begin
      tap_port.en   = 1'b1;
      tap_port.addr = tap_run_addr;
    end else if (wr_fire && (awaddr_q >= fir_pkg::tap_base)) begin
      tap_port.we   = 4'hf;
      tap_port.en   = 1'b1;
      tap_port.addr = awaddr_q - fir_pkg::tap_base;
      tap_port.di   = wdata_q;
    end else if (ar_fire && (araddr >= fir_pkg::tap_base)) begin
      tap_port.en   = 1'b1;
      tap_port.addr = araddr - fir_pkg::tap_base;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fir_ap_fsm.sv
// run sequencer; expects one-cycle registered RAM reads and a two-stage MAC behind it
`default_nettype none

module fir_ap_fsm (
  input  wire                 axis_clk,
  input  wire                 axis_rst_n,
  input  wire                 start,
  input  wire                 done_ack,
  input  wire                 clear_last,
  input  wire                 tap_last,
  input  wire                 out_last,
  input  wire                 ss_tvalid,
  input  wire                 sm_tready,
  output fir_pkg::run_state_t state,
  output logic                ss_tready,
  output logic                sm_tvalid,
  output logic                sm_tlast,
  output fir_pkg::mac_ctl_t   mac_ctl
);
  fir_pkg::run_state_t state_next;
  logic [1:0]          drain_cnt;
  logic                drain_end;
  logic                wx_q;
  logic                mac_en_q;
  logic                mac_first_q;

  assign drain_end = (state == fir_pkg::drain) && (drain_cnt == 2'd1);

  always_comb begin
    state_next = state;
    case (state)
      fir_pkg::idle: begin
        if (start) begin
          state_next = fir_pkg::clear;
        end
      end
      fir_pkg::clear: begin
        if (clear_last) begin
          state_next = fir_pkg::wait_in;
        end
      end
      fir_pkg::wait_in: begin
        if (ss_tvalid) begin
          state_next = fir_pkg::write_x;
        end
      end
      fir_pkg::write_x: begin
        state_next = fir_pkg::accum;
      end
      fir_pkg::accum: begin
        if (tap_last) begin
          state_next = fir_pkg::drain;
        end
      end
      fir_pkg::drain: begin
        if (drain_end) begin
          state_next = fir_pkg::out_hold;
        end
      end
      fir_pkg::out_hold: begin
        // no new sample until this output is taken
        if (sm_tready) begin
          state_next = out_last ? fir_pkg::done : fir_pkg::wait_in;
        end
      end
      fir_pkg::done: begin
        if (done_ack) begin
          state_next = fir_pkg::idle;
        end
      end
      default: begin
        state_next = fir_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state       <= fir_pkg::idle;
      drain_cnt   <= 2'd0;
      wx_q        <= 1'b0;
      mac_en_q    <= 1'b0;
      mac_first_q <= 1'b0;
    end else begin
      state       <= state_next;
      drain_cnt   <= (state == fir_pkg::drain) ? drain_cnt + 2'd1 : 2'd0;
      // RAM data lags the accum address by one cycle
      wx_q        <= (state == fir_pkg::write_x);
      mac_en_q    <= (state == fir_pkg::accum);
      mac_first_q <= (state == fir_pkg::accum) && wx_q;
    end
  end

  assign mac_ctl = '{mac_en: mac_en_q, mac_first: mac_first_q, load_out: drain_end};

  assign ss_tready = (state == fir_pkg::wait_in);
  assign sm_tvalid = (state == fir_pkg::out_hold);
  assign sm_tlast  = sm_tvalid && out_last;

endmodule

`default_nettype wire

//--- hdl/fir_addr_gen.sv
// data RAM window of coef_length words at byte address 0; coef_length must not change during a run
`default_nettype none

module fir_addr_gen #(
  parameter int num_taps_max = 32
) (
  input  wire                        axis_clk,
  input  wire                        axis_rst_n,
  input  wire fir_pkg::run_state_t   state,
  input  wire fir_pkg::fir_cfg_t     cfg,
  input  wire [fir_pkg::data_w-1:0]  ss_tdata,
  input  wire                        sm_tready,
  output fir_pkg::bram_port_t        data_port,
  output logic [fir_pkg::addr_w-1:0] tap_run_addr,
  output logic                       clear_last,
  output logic                       tap_last,
  output logic                       out_last
);
  localparam int unsigned aw = fir_pkg::addr_w;
  localparam int unsigned dw = fir_pkg::data_w;
  localparam logic [aw-1:0] clear_top = aw'(num_taps_max - 1);
  localparam logic [aw-1:0] a_one = aw'(1);
  localparam logic [dw-1:0] d_one = dw'(1);

  logic [aw-1:0] clear_idx;
  logic [aw-1:0] wptr;
  logic [aw-1:0] rptr;
  logic [aw-1:0] tap_idx;
  logic [aw-1:0] coef_top;
  logic [dw-1:0] out_cnt;
  logic [dw-1:0] sample_q;

  assign coef_top   = cfg.coef_length[aw-1:0] - a_one;
  assign clear_last = (clear_idx == clear_top);
  assign tap_last   = (tap_idx == coef_top);
  assign out_last   = (out_cnt == cfg.data_length - d_one);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      clear_idx <= '0;
      tap_idx   <= '0;
      wptr      <= '0;
      rptr      <= '0;
      out_cnt   <= '0;
    end else begin
      clear_idx <= (state == fir_pkg::clear) ? clear_idx + a_one : '0;
      tap_idx   <= (state == fir_pkg::accum) ? tap_idx + a_one : '0;
      case (state)
        fir_pkg::clear: begin
          wptr    <= '0;
          out_cnt <= '0;
        end
        fir_pkg::write_x: begin
          // read walk starts at the sample being written
          rptr <= wptr;
          wptr <= (wptr == coef_top) ? '0 : wptr + a_one;
        end
        fir_pkg::accum: begin
          rptr <= (rptr == '0) ? coef_top : rptr - a_one;
        end
        fir_pkg::out_hold: begin
          if (sm_tready) begin
            out_cnt <= out_cnt + d_one;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // last value seen in wait_in is the accepted sample
  always_ff @(posedge axis_clk) begin
    if (state == fir_pkg::wait_in) begin
      sample_q <= ss_tdata;
    end
  end

  always_comb begin
    data_port = '0;
    case (state)
      fir_pkg::clear: begin
        data_port.we   = 4'hf;
        data_port.en   = 1'b1;
        data_port.addr = {clear_idx[aw-3:0], 2'b00};
      end
      fir_pkg::write_x: begin
        data_port.we   = 4'hf;
        data_port.en   = 1'b1;
        data_port.addr = {wptr[aw-3:0], 2'b00};
        data_port.di   = sample_q;
      end
      fir_pkg::accum: begin
        data_port.en   = 1'b1;
        data_port.addr = {rptr[aw-3:0], 2'b00};
      end
      default: begin
      end
    endcase
  end

  assign tap_run_addr = {tap_idx[aw-3:0], 2'b00};

endmodule

`default_nettype wire

//--- hdl/fir_mac.sv
// 32-bit wrapping multiply-accumulate; inputs must be valid in the cycle mac_en is high
`default_nettype none

module fir_mac (
  input  wire                        axis_clk,
  input  wire                        axis_rst_n,
  input  wire fir_pkg::mac_ctl_t     mac_ctl,
  input  wire [fir_pkg::data_w-1:0]  data_do,
  input  wire [fir_pkg::data_w-1:0]  tap_do,
  output logic [fir_pkg::data_w-1:0] sm_tdata
);
  localparam int unsigned dw = fir_pkg::data_w;

  logic [dw-1:0] prod;
  logic [dw-1:0] acc;
  logic [dw-1:0] acc_next;
  logic          en_d;
  logic          first_d;

  // stage one flags travel with the product
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      en_d    <= 1'b0;
      first_d <= 1'b0;
    end else begin
      en_d    <= mac_ctl.mac_en;
      first_d <= mac_ctl.mac_en && mac_ctl.mac_first;
    end
  end

  // first product of an output restarts the sum
  assign acc_next = first_d ? prod : acc + prod;

  always_ff @(posedge axis_clk) begin
    if (mac_ctl.mac_en) begin
      prod <= data_do * tap_do;
    end
    if (en_d) begin
      acc <= acc_next;
    end
    // load_out comes with the last product, so take the sum including it
    if (mac_ctl.load_out) begin
      sm_tdata <= acc_next;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fir_pkg.sv
// shared FIR definitions; addresses are byte addresses on a 12-bit AXI-Lite bus, 32-bit data only
`default_nettype none

package fir_pkg;

  // bus widths
  localparam int addr_w = 12;
  localparam int data_w = 32;

  // AXI-Lite register map
  localparam logic [addr_w-1:0] reg_ap_ctrl     = 12'h000;
  localparam logic [addr_w-1:0] reg_data_length = 12'h010;
  localparam logic [addr_w-1:0] reg_coef_length = 12'h014;
  localparam logic [addr_w-1:0] tap_base        = 12'h080;

  // ap_ctrl bit positions
  localparam int ap_start_bit = 0;
  localparam int ap_done_bit  = 1;
  localparam int ap_idle_bit  = 2;

  // run states of the engine
  typedef enum logic [2:0] {
    idle     = 3'd0,
    clear    = 3'd1,
    wait_in  = 3'd2,
    write_x  = 3'd3,
    accum    = 3'd4,
    drain    = 3'd5,
    out_hold = 3'd6,
    done     = 3'd7
  } run_state_t;

  typedef struct packed {
    logic [data_w-1:0] data_length;
    logic [data_w-1:0] coef_length;
  } fir_cfg_t;

  // one BRAM port, same layout for tap and data RAM
  typedef struct packed {
    logic [3:0]        we;
    logic              en;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] di;
  } bram_port_t;

  typedef struct packed {
    logic mac_en;
    logic mac_first;
    logic load_out;
  } mac_ctl_t;

endpackage

`default_nettype wire
